/* verilog/cpu_pkg.sv */
package cpu_pkg;

    localparam int XLEN = 32;

    // RV32I major opcodes
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR
    } alu_op_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] rs1_value;
        logic [XLEN-1:0] rs2_value;
        logic [XLEN-1:0] imm;
        alu_op_t         alu_op;
        logic            alu_src_imm; // Second operand is imm
        logic            branch;
        logic            mem_read;
        logic            mem_write;
        logic            reg_write;
        logic [4:0]      rd;
    } de_ex_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] result;    // ALU result or byte address
        logic [XLEN-1:0] rs2_value; // Store data
        logic            mem_read;
        logic            mem_write;
        logic            reg_write;
        logic [4:0]      rd;
    } ex_mem_t;

    // Register write port
    typedef struct packed {
        logic            valid;
        logic            reg_write;
        logic [4:0]      rd;
        logic [XLEN-1:0] data;
    } mem_wb_t;

endpackage

/* verilog/cpu_buses.sv */
`timescale 1ns/10ps

// Data RAM port, word addressed
interface ram_bus #(
    parameter int ADDR_W = 6
);
    logic [ADDR_W-1:0]        addr;
    logic [cpu_pkg::XLEN-1:0] wdata;
    logic                     we;
    logic [cpu_pkg::XLEN-1:0] rdata; // Combinational read

    modport master (output addr, output wdata, output we, input rdata);
    modport slave (input addr, input wdata, input we, output rdata);
endinterface

// Two read ports of the register file
interface rf_read_bus;
    logic [4:0]               addr1;
    logic [4:0]               addr2;
    logic [cpu_pkg::XLEN-1:0] value1;
    logic [cpu_pkg::XLEN-1:0] value2;

    modport requester (output addr1, output addr2, input value1, input value2);
    modport responder (input addr1, input addr2, output value1, output value2);
endinterface

/* verilog/register_bank.sv */
`timescale 1ns/10ps

module register_bank #(
    parameter int LED_REG = 1
) (
    input  logic                clock,
    input  logic                rst,
    input  logic                enable,
    rf_read_bus.responder       rf,
    input  cpu_pkg::mem_wb_t    wb,
    output logic [5:0]          led
);
    logic [cpu_pkg::XLEN-1:0] regs [32];
    logic                     wr_active;

    assign wr_active = wb.valid && wb.reg_write && (wb.rd != 5'd0); // x0 never written

    always_ff @(posedge clock) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (enable && wr_active) begin
            regs[wb.rd] <= wb.data;
        end
    end

    // Write-through so a reader in the same cycle sees the new value
    assign rf.value1 = (wr_active && wb.rd == rf.addr1) ? wb.data : regs[rf.addr1];
    assign rf.value2 = (wr_active && wb.rd == rf.addr2) ? wb.data : regs[rf.addr2];

    assign led = regs[LED_REG][5:0];

    a_x0_zero: assert property (@(posedge clock) disable iff (rst)
        (rf.addr1 == 5'd0) |-> (rf.value1 == '0) && (regs[0] == '0));

endmodule

/* verilog/fetch.sv */
`timescale 1ns/10ps

module fetch (
    input  logic                     clock,
    input  logic                     rst,
    input  logic                     enable,
    input  logic                     branch_taken,
    input  logic [cpu_pkg::XLEN-1:0] branch_target,
    input  logic [31:0]              rom_data,
    output logic [7:0]               rom_address,
    output logic [31:0]              instr,
    output logic [cpu_pkg::XLEN-1:0] pc,
    output logic                     valid
);
    logic [cpu_pkg::XLEN-1:0] fetch_pc; // Address being fetched now

    assign rom_address = fetch_pc[9:2];

    always_ff @(posedge clock) begin
        if (rst) begin
            fetch_pc <= '0;
            valid    <= 1'b0;
        end else if (enable) begin
            if (branch_taken) begin
                fetch_pc <= branch_target;
                valid    <= 1'b0; // Squash the wrong-path fetch
            end else begin
                fetch_pc <= fetch_pc + 32'd4;
                valid    <= 1'b1;
            end
            instr <= rom_data;
            pc    <= fetch_pc;
        end
    end

    a_target_aligned: assert property (@(posedge clock) disable iff (rst)
        branch_taken |-> (branch_target[1:0] == 2'b00));

endmodule

/* verilog/decode.sv */
`timescale 1ns/10ps

module decode (
    input  logic                     clock,
    input  logic                     rst,
    input  logic                     enable,
    input  logic [31:0]              instr,
    input  logic [cpu_pkg::XLEN-1:0] pc,
    input  logic                     valid,
    input  logic                     flush,
    rf_read_bus.requester            rf,
    output cpu_pkg::de_ex_t          de_ex
);
    logic [6:0]               opcode;
    logic [4:0]               rd;
    logic [2:0]               funct3;
    logic [6:0]               funct7;
    logic [cpu_pkg::XLEN-1:0] imm_i;
    logic [cpu_pkg::XLEN-1:0] imm_s;
    logic [cpu_pkg::XLEN-1:0] imm_b;
    cpu_pkg::de_ex_t          de_ex_d;

    assign opcode = instr[6:0];
    assign rd     = instr[11:7];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};

    assign rf.addr1 = instr[19:15];
    assign rf.addr2 = instr[24:20];

    always_comb begin
        de_ex_d           = '0; // Default is a no-op
        de_ex_d.valid     = valid && !flush;
        de_ex_d.pc        = pc;
        de_ex_d.rs1_value = rf.value1;
        de_ex_d.rs2_value = rf.value2;
        de_ex_d.rd        = rd;
        de_ex_d.alu_op    = cpu_pkg::ALU_ADD;
        case (opcode)
            cpu_pkg::OP_REG: begin
                de_ex_d.reg_write = 1'b1;
                case ({funct7, funct3})
                    {7'b0000000, 3'b000}: de_ex_d.alu_op = cpu_pkg::ALU_ADD;
                    {7'b0100000, 3'b000}: de_ex_d.alu_op = cpu_pkg::ALU_SUB;
                    {7'b0000000, 3'b111}: de_ex_d.alu_op = cpu_pkg::ALU_AND;
                    {7'b0000000, 3'b110}: de_ex_d.alu_op = cpu_pkg::ALU_OR;
                    {7'b0000000, 3'b100}: de_ex_d.alu_op = cpu_pkg::ALU_XOR;
                    default:              de_ex_d.reg_write = 1'b0;
                endcase
            end
            cpu_pkg::OP_IMM: begin
                if (funct3 == 3'b000) begin // ADDI only
                    de_ex_d.reg_write   = 1'b1;
                    de_ex_d.alu_src_imm = 1'b1;
                    de_ex_d.imm         = imm_i;
                end
            end
            cpu_pkg::OP_LOAD: begin
                if (funct3 == 3'b010) begin // LW
                    de_ex_d.mem_read    = 1'b1;
                    de_ex_d.reg_write   = 1'b1;
                    de_ex_d.alu_src_imm = 1'b1;
                    de_ex_d.imm         = imm_i;
                end
            end
            cpu_pkg::OP_STORE: begin
                if (funct3 == 3'b010) begin // SW
                    de_ex_d.mem_write   = 1'b1;
                    de_ex_d.alu_src_imm = 1'b1;
                    de_ex_d.imm         = imm_s;
                end
            end
            cpu_pkg::OP_BRANCH: begin
                if (funct3 == 3'b000) begin // BEQ
                    de_ex_d.branch = 1'b1;
                    de_ex_d.imm    = imm_b;
                end
            end
            default: ;
        endcase
        if (rd == 5'd0) de_ex_d.reg_write = 1'b0;
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            de_ex.valid <= 1'b0;
        end else if (enable) begin
            de_ex <= de_ex_d;
        end
    end

endmodule

/* verilog/execute.sv */
`timescale 1ns/10ps

module execute (
    input  logic                     clock,
    input  logic                     rst,
    input  logic                     enable,
    input  cpu_pkg::de_ex_t          de_ex,
    output logic                     branch_taken,
    output logic [cpu_pkg::XLEN-1:0] branch_target,
    output cpu_pkg::ex_mem_t         ex_mem
);
    logic [cpu_pkg::XLEN-1:0] operand_b;
    logic [cpu_pkg::XLEN-1:0] result;

    assign operand_b = de_ex.alu_src_imm ? de_ex.imm : de_ex.rs2_value;

    always_comb begin
        case (de_ex.alu_op)
            cpu_pkg::ALU_SUB: result = de_ex.rs1_value - operand_b;
            cpu_pkg::ALU_AND: result = de_ex.rs1_value & operand_b;
            cpu_pkg::ALU_OR:  result = de_ex.rs1_value | operand_b;
            cpu_pkg::ALU_XOR: result = de_ex.rs1_value ^ operand_b;
            default:          result = de_ex.rs1_value + operand_b;
        endcase
    end

    // BEQ resolves here, two younger slots get squashed
    assign branch_taken  = de_ex.valid && de_ex.branch && (de_ex.rs1_value == de_ex.rs2_value);
    assign branch_target = de_ex.pc + de_ex.imm;

    always_ff @(posedge clock) begin
        if (rst) begin
            ex_mem.valid <= 1'b0;
        end else if (enable) begin
            ex_mem.valid     <= de_ex.valid;
            ex_mem.result    <= result;
            ex_mem.rs2_value <= de_ex.rs2_value;
            ex_mem.mem_read  <= de_ex.mem_read;
            ex_mem.mem_write <= de_ex.mem_write;
            ex_mem.reg_write <= de_ex.reg_write;
            ex_mem.rd        <= de_ex.rd;
        end
    end

    a_mem_excl: assert property (@(posedge clock) disable iff (rst)
        de_ex.valid |-> !(de_ex.mem_read && de_ex.mem_write));

endmodule

/* verilog/ram.sv */
`timescale 1ns/10ps

module ram #(
    parameter int RAM_WORDS = 64
) (
    input  logic    clock,
    input  logic    enable,
    ram_bus.slave   bus
);
    logic [cpu_pkg::XLEN-1:0] words [RAM_WORDS];

    always_ff @(posedge clock) begin
        if (enable && bus.we) begin
            words[bus.addr] <= bus.wdata;
        end
    end

    assign bus.rdata = words[bus.addr]; // Same-cycle read

    // Catches a non power of two size being overrun
    a_addr_range: assert property (@(posedge clock)
        (enable && bus.we) |-> (int'(bus.addr) < RAM_WORDS));

endmodule

/* verilog/memory.sv */
`timescale 1ns/10ps

module memory #(
    parameter int RAM_WORDS = 64
) (
    input  logic              clock,
    input  logic              rst,
    input  logic              enable,
    input  cpu_pkg::ex_mem_t  ex_mem,
    ram_bus.master            ram,
    output cpu_pkg::mem_wb_t  mem_wb
);
    localparam int AW = $clog2(RAM_WORDS);

    logic [cpu_pkg::XLEN-1:0] wb_data;

    // Word index from the byte address
    assign ram.addr  = ex_mem.result[AW+1:2];
    assign ram.wdata = ex_mem.rs2_value;
    assign ram.we    = ex_mem.valid && ex_mem.mem_write;

    assign wb_data = ex_mem.mem_read ? ram.rdata : ex_mem.result; // Load or ALU

    always_ff @(posedge clock) begin
        if (rst) begin
            mem_wb.valid <= 1'b0;
        end else if (enable) begin
            mem_wb.valid     <= ex_mem.valid;
            mem_wb.reg_write <= ex_mem.reg_write;
            mem_wb.rd        <= ex_mem.rd;
            mem_wb.data      <= wb_data;
        end
    end

endmodule

/* verilog/cpu.sv */
`timescale 1ns/10ps

module cpu #(
    parameter int RAM_WORDS = 64,
    parameter int LED_REG   = 1
) (
    input  logic        clock,
    input  logic        rst,
    input  logic        enable,
    input  logic [31:0] rom_data,
    output logic [7:0]  rom_address,
    output logic [5:0]  led
);
    logic [31:0]              if_instr;
    logic [cpu_pkg::XLEN-1:0] if_pc;
    logic                     if_valid;
    cpu_pkg::de_ex_t          de_ex;
    cpu_pkg::ex_mem_t         ex_mem;
    cpu_pkg::mem_wb_t         mem_wb;
    logic                     branch_taken;
    logic [cpu_pkg::XLEN-1:0] branch_target;

    ram_bus #(.ADDR_W($clog2(RAM_WORDS))) ram_if ();
    rf_read_bus rf_if ();

    fetch u_fetch (
        .clock(clock), .rst(rst), .enable(enable),
        .branch_taken(branch_taken), .branch_target(branch_target),
        .rom_data(rom_data), .rom_address(rom_address),
        .instr(if_instr), .pc(if_pc), .valid(if_valid)
    );

    decode u_decode (
        .clock(clock), .rst(rst), .enable(enable),
        .instr(if_instr), .pc(if_pc), .valid(if_valid),
        .flush(branch_taken), // Taken BEQ kills the decode slot
        .rf(rf_if.requester), .de_ex(de_ex)
    );

    execute u_execute (
        .clock(clock), .rst(rst), .enable(enable), .de_ex(de_ex),
        .branch_taken(branch_taken), .branch_target(branch_target), .ex_mem(ex_mem)
    );

    memory #(.RAM_WORDS(RAM_WORDS)) u_memory (
        .clock(clock), .rst(rst), .enable(enable),
        .ex_mem(ex_mem), .ram(ram_if.master), .mem_wb(mem_wb)
    );

    ram #(.RAM_WORDS(RAM_WORDS)) u_ram (
        .clock(clock), .enable(enable), .bus(ram_if.slave)
    );

    register_bank #(.LED_REG(LED_REG)) u_register_bank (
        .clock(clock), .rst(rst), .enable(enable),
        .rf(rf_if.responder), .wb(mem_wb), .led(led)
    );

endmodule

/* tests/tb_clock.sv */
`timescale 1ns/10ps

module tb_clock #(
    parameter int PERIOD       = 100,
    parameter int RESET_CYCLES = 3
) (
    output logic clock,
    output logic rst
);
    initial begin
        clock = 1'b0;
        forever #(PERIOD / 2) clock = ~clock;
    end

    // Power-on reset, released on a falling edge
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
        rst = 1'b0;
    end
endmodule

/* tests/cpu_tb.sv */
`timescale 1ns/10ps

module cpu_tb;
    localparam int CLOCK_PERIOD = 100;
    localparam int RESET_CYCLES = 3;
    localparam int ARITH_EDGES  = 29;
    localparam int MEMORY_EDGES = 26;
    localparam int BRANCH_EDGES = 19;
    localparam int RESET_EDGES  = 8;
    localparam int STALL_EDGES  = 20;
    // Stalled run gets four cycles per enabled edge
    localparam int TEST_CYCLES  = ARITH_EDGES + MEMORY_EDGES + BRANCH_EDGES + RESET_EDGES
                                + 4 * STALL_EDGES + 6 * (RESET_CYCLES + 2);
    localparam int WATCHDOG_NS  = (TEST_CYCLES + 50) * CLOCK_PERIOD;
    localparam logic [31:0] NOP    = 32'h0000_0013; // addi x0, x0, 0
    localparam logic [6:0]  F7_STD = 7'b0000000;
    localparam logic [6:0]  F7_SUB = 7'b0100000;

    logic        clock;
    logic        por_rst;
    logic        test_rst;
    logic        cpu_rst;
    logic        enable;
    logic [31:0] rom [0:255];
    logic [31:0] rom_data;
    logic [7:0]  rom_address;
    logic [5:0]  led;
    int          fail_count = 0;
    int          led_edges[$];   // Enabled edge count after reset release
    logic [31:0] led_values[$];
    int          addr_edges[$];
    logic [31:0] addr_values[$];

    tb_clock #(.PERIOD(CLOCK_PERIOD), .RESET_CYCLES(RESET_CYCLES)) u_clock (
        .clock(clock), .rst(por_rst)
    );

    assign cpu_rst  = por_rst || test_rst;
    assign rom_data = rom[rom_address]; // Combinational ROM

    cpu #(.RAM_WORDS(64), .LED_REG(1)) u_cpu (
        .clock(clock), .rst(cpu_rst), .enable(enable),
        .rom_data(rom_data), .rom_address(rom_address), .led(led)
    );

    function automatic logic [31:0] sext12(input logic [11:0] value);
        return {{20{value[11]}}, value};
    endfunction

    // RV32I encodings
    function automatic logic [31:0] reg_op(input logic [6:0] funct7, input logic [2:0] funct3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [4:0] rs2);
        return {funct7, rs2, rs1, funct3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] addi(input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] lw(input logic [4:0] rd, input logic [4:0] rs1,
                                       input logic [11:0] imm);
        return {imm, rs1, 3'b010, rd, 7'b0000011};
    endfunction

    function automatic logic [31:0] sw(input logic [4:0] rs2, input logic [4:0] rs1,
                                       input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] beq(input logic [4:0] rs1, input logic [4:0] rs2,
                                        input logic [12:0] offset);
        return {offset[12], offset[10:5], rs2, rs1, 3'b000, offset[4:1], offset[11], 7'b1100011};
    endfunction

    task automatic check_equal(input string what, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            fail_count++;
            $display("Fail at %0d ns: %s is 0x%0h, expected 0x%0h", $time, what, actual,
                     expected);
            $display("*** FAILED ***");
            $fatal(1, "Stopping at the first mismatch");
        end
    endtask

    task automatic expect_led(input int edge_no, input logic [31:0] value);
        led_edges.push_back(edge_no);
        led_values.push_back(value & 32'h3f); // led shows bits 5:0 of x1
    endtask

    task automatic expect_address(input int edge_no, input logic [31:0] value);
        addr_edges.push_back(edge_no);
        addr_values.push_back(value);
    endtask

    // Ends on a falling edge with reset still high
    task automatic hold_reset();
        @(negedge clock);
        test_rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
    endtask

    task automatic clear_program();
        for (int i = 0; i < 256; i++) begin
            rom[i] = NOP;
        end
        led_edges.delete();
        led_values.delete();
        addr_edges.delete();
        addr_values.delete();
    endtask

    // Counts enabled edges and checks each expectation at its edge
    task automatic run_program(input int edges, input bit stall);
        int         done;
        logic [7:0] held_address;
        logic [5:0] held_led;
        logic       was_enabled;
        done = 0;
        while (done < edges) begin
            held_address = rom_address;
            held_led     = led;
            was_enabled  = enable;
            @(posedge clock);
            @(negedge clock);
            if (was_enabled) begin
                done++;
                while (led_edges.size() > 0 && led_edges[0] == done) begin
                    check_equal("led", 32'(led), led_values[0]);
                    led_edges.delete(0);
                    led_values.delete(0);
                end
                while (addr_edges.size() > 0 && addr_edges[0] == done) begin
                    check_equal("rom_address", 32'(rom_address), addr_values[0]);
                    addr_edges.delete(0);
                    addr_values.delete(0);
                end
            end else begin
                check_equal("rom_address while disabled", 32'(rom_address), 32'(held_address));
                check_equal("led while disabled", 32'(led), 32'(held_led));
            end
            enable = stall ? ($urandom_range(3) != 0) : 1'b1; // Low about one cycle in four
        end
        enable = 1'b1;
    endtask

    task automatic arithmetic_chain();
        logic [11:0] imm_a;
        logic [11:0] imm_b;
        logic [31:0] a;
        logic [31:0] b;
        imm_a = 12'($urandom);
        imm_b = 12'($urandom);
        a     = sext12(imm_a);
        b     = sext12(imm_b);
        hold_reset();
        clear_program();
        rom[0]  = addi(5'd2, 5'd0, imm_a);
        rom[3]  = addi(5'd3, 5'd0, imm_b);
        rom[6]  = reg_op(F7_STD, 3'b000, 5'd1, 5'd2, 5'd3); // add
        rom[9]  = reg_op(F7_SUB, 3'b000, 5'd1, 5'd2, 5'd3); // sub
        rom[12] = reg_op(F7_STD, 3'b111, 5'd1, 5'd2, 5'd3); // and
        rom[15] = reg_op(F7_STD, 3'b110, 5'd1, 5'd2, 5'd3); // or
        rom[18] = reg_op(F7_STD, 3'b100, 5'd1, 5'd2, 5'd3); // xor
        rom[21] = reg_op(F7_SUB, 3'b000, 5'd4, 5'd1, 5'd2);
        rom[24] = reg_op(F7_STD, 3'b000, 5'd1, 5'd4, 5'd3);
        expect_led(11, a + b);
        expect_led(14, a - b);
        expect_led(17, a & b);
        expect_led(20, a | b);
        expect_led(23, a ^ b);
        expect_led(29, ((a ^ b) - a) + b);
        test_rst = 1'b0;
        run_program(ARITH_EDGES, 1'b0);
    endtask

    task automatic memory_roundtrip();
        logic [11:0] imm_a;
        logic [11:0] imm_b;
        logic [11:0] imm_c;
        logic [31:0] sum;
        imm_a = 12'($urandom);
        imm_b = 12'($urandom);
        sum   = sext12(imm_a) + sext12(imm_b);
        imm_c = {6'($urandom), sum[5:0] ^ 6'h2a}; // Differs from sum on led
        hold_reset();
        clear_program();
        rom[0]  = addi(5'd2, 5'd0, imm_a);
        rom[3]  = addi(5'd3, 5'd0, imm_b);
        rom[6]  = reg_op(F7_STD, 3'b000, 5'd5, 5'd2, 5'd3);
        rom[9]  = addi(5'd6, 5'd0, imm_c);
        rom[12] = sw(5'd5, 5'd0, 12'd8);
        rom[15] = sw(5'd6, 5'd0, 12'd12);
        rom[18] = lw(5'd1, 5'd0, 12'd8);
        rom[21] = lw(5'd1, 5'd0, 12'd12);
        expect_led(23, sum);
        expect_led(26, sext12(imm_c));
        test_rst = 1'b0;
        run_program(MEMORY_EDGES, 1'b0);
    endtask

    task automatic branch_squash();
        logic [11:0] imm_a;
        imm_a = 12'($urandom);
        hold_reset();
        clear_program();
        rom[0]  = addi(5'd2, 5'd0, imm_a);
        rom[3]  = addi(5'd3, 5'd0, imm_a);
        rom[6]  = beq(5'd2, 5'd3, 13'd16);  // Taken to word 10
        rom[7]  = addi(5'd1, 5'd0, 12'd33); // Squashed
        rom[8]  = addi(5'd1, 5'd0, 12'd34); // Squashed
        rom[9]  = addi(5'd1, 5'd0, 12'd35); // Never fetched
        rom[10] = addi(5'd3, 5'd0, imm_a ^ 12'h001);
        rom[13] = beq(5'd2, 5'd3, 13'd16);  // Not taken
        rom[14] = addi(5'd1, 5'd0, 12'd21);
        rom[15] = addi(5'd1, 5'd0, 12'd22);
        // Word n at edge n-1 once the redirect has happened
        expect_address(8, 32'd8);
        expect_address(9, 32'd10);
        expect_address(13, 32'd14);
        expect_led(13, 32'd0);
        expect_led(17, 32'd0);
        expect_led(18, 32'd21);
        expect_led(19, 32'd22);
        test_rst = 1'b0;
        run_program(BRANCH_EDGES, 1'b0);
    endtask

    task automatic reset_state();
        hold_reset();
        clear_program();
        test_rst = 1'b0;
        check_equal("rom_address after reset", 32'(rom_address), 32'd0);
        check_equal("led after reset", 32'(led), 32'd0);
        for (int i = 1; i <= RESET_EDGES; i++) begin
            expect_address(i, i);
        end
        expect_led(RESET_EDGES, 32'd0);
        run_program(RESET_EDGES, 1'b0);
    endtask

    task automatic stall_and_x0();
        logic [11:0] imm_a;
        logic [11:0] imm_b;
        imm_a = 12'($urandom);
        imm_b = 12'($urandom);
        hold_reset();
        clear_program();
        rom[0]  = addi(5'd2, 5'd0, imm_a);
        rom[3]  = addi(5'd3, 5'd0, imm_b);
        rom[6]  = reg_op(F7_STD, 3'b100, 5'd1, 5'd2, 5'd3);
        rom[9]  = addi(5'd1, 5'd0, 12'd42);
        rom[12] = addi(5'd0, 5'd0, 12'd21); // Write to x0 is dropped
        rom[15] = reg_op(F7_STD, 3'b000, 5'd1, 5'd0, 5'd0);
        expect_led(11, sext12(imm_a) ^ sext12(imm_b));
        expect_led(14, 32'd42);
        expect_led(17, 32'd42);
        expect_led(20, 32'd0);
        test_rst = 1'b0;
        run_program(STALL_EDGES, 1'b1);
    endtask

    initial begin
        void'($urandom(32'ha3e));
        test_rst = 1'b0;
        enable   = 1'b1;
        for (int i = 0; i < 256; i++) begin
            rom[i] = NOP;
        end
        wait (!por_rst);
        arithmetic_chain();
        memory_roundtrip();
        branch_squash();
        reset_state();
        stall_and_x0();
        if (fail_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog timeout, tests did not finish within %0d ns", WATCHDOG_NS);
        $display("*** FAILED ***");
        $fatal(1, "Watchdog timeout");
    end
endmodule

/* mini_rv_pipe.f */
verilog/cpu_pkg.sv
verilog/cpu_buses.sv
verilog/register_bank.sv
verilog/fetch.sv
verilog/decode.sv
verilog/execute.sv
verilog/ram.sv
verilog/memory.sv
verilog/cpu.sv
tests/tb_clock.sv
tests/cpu_tb.sv

/* run.sh */
#!/bin/sh
set -e

verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module cpu_tb -f mini_rv_pipe.f

./obj_dir/Vcpu_tb | tee sim.log

if grep -q -F '*** FAILED ***' sim.log; then
    echo "Simulation reported errors"
    exit 1
fi
if ! grep -q -F '*** PASSED ***' sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
echo "Simulation finished cleanly"
